// ==== romPkg.sv ====
package romPkg;

	// Field widths of the ROM side of the P bus
	localparam int sRomAddrWidth = 16;	// Fix ROM address lines
	localparam int cRomAddrWidth = 24;	// Sprite C ROM address lines
	localparam int l0RomAddrWidth = 16;	// Line zoom ROM address lines
	localparam int romByteWidth = 8;	// Byte-wide ROM data
	localparam int palNibbleWidth = 4;	// Fix palette index

	// Fix ROM address as it sits on the low two bus bytes
	typedef logic [sRomAddrWidth-1:0] sRomAddr;

	// Sprite C ROM address takes the whole bus
	typedef logic [cRomAddrWidth-1:0] cRomAddr;

	// L0 ROM address seen while nVCS is low
	typedef logic [l0RomAddrWidth-1:0] l0RomAddr;

	// One data byte
	// Also carries sprite X position and sprite palette
	typedef logic [romByteWidth-1:0] romByte;

	// Fix palette number
	typedef logic [palNibbleWidth-1:0] palNibble;

endpackage

// ==== pbusPkg.sv ====
package pbusPkg;

	localparam int slotBits = 4;	// 16 slots per frame
	localparam int pbusWidth = 24;	// Shared bus width

	typedef logic [slotBits-1:0] slotIndex;	// Slot number 0 to 15
	typedef logic [pbusWidth-1:0] pbusWord;	// One bus word

	// Slot map boundaries
	localparam slotIndex fixAddrSlot = 4'd0;	// Fix ROM address
	localparam slotIndex xPosFirstSlot = 4'd1;	// Sprite X window start
	localparam slotIndex xPosLastSlot = 4'd5;	// Sprite X window end
	localparam slotIndex fixPalSlot = 4'd6;	// Fix palette
	localparam slotIndex sprAddrSlot = 4'd8;	// Sprite C ROM address
	localparam slotIndex l0FirstSlot = 4'd9;	// First nVCS cycle
	localparam slotIndex l0LastSlot = 4'd13;	// Last nVCS cycle
	localparam slotIndex sprPalSlot = 4'd14;	// Sprite palette
	localparam slotIndex frameEndSlot = 4'd15;	// Idle and request reload

	// What the bus carries in a slot
	typedef enum logic [2:0] {
		SLOT_FIX_ADDR,	// Slot 0
		SLOT_XPOS,	// Slots 1 to 5
		SLOT_FIX_PAL,	// Slot 6
		SLOT_SPR_ADDR,	// Slot 8
		SLOT_L0_ADDR,	// Slots 9 to 13
		SLOT_SPR_PAL,	// Slot 14
		SLOT_IDLE	// Slots 7 and 15
	} slotKind;

	// Address sources for one frame
	typedef struct packed {
		romPkg::sRomAddr sAddr;	// Fix tile row address
		romPkg::palNibble fixPal;	// Fix palette
		romPkg::cRomAddr cAddr;	// Sprite tile address
		romPkg::romByte sprPal;	// Sprite palette
		romPkg::romByte sprXPos;	// Sprite X position
		romPkg::l0RomAddr l0Addr;	// Line zoom lookup
	} pbusRequest;

	// Values held by the latches on the ROM boards
	typedef struct packed {
		romPkg::sRomAddr fixRomAddr;	// Fix ROM address latch
		romPkg::romByte sprXPos;	// X position latch
		romPkg::palNibble fixPal;	// Fix palette latch
		romPkg::cRomAddr sprRomAddr;	// C ROM address latch
		romPkg::romByte sprPal;	// Sprite palette latch
		romPkg::romByte l0Data;	// Zoom ROM byte
	} pbusCapture;

endpackage

// ==== pbusRequestLatch.sv ====
`timescale 1ns/1ps

module pbusRequestLatch (
	input logic CLK_24M,
	input logic nRESET,
	input logic frameLoad,	// High in slot 15 only
	input pbusPkg::pbusRequest reqIn,	// Free-running sources
	output pbusPkg::pbusRequest reqHeld	// Stable for a whole frame
);

	// Sources may move at any time
	// The bus must see one set per frame
	// Loaded on the edge that closes slot 15 so slot 0 sees new values
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			reqHeld <= '0;	// First frame after reset carries zeros
		else if (frameLoad)
			reqHeld <= reqIn;	// Take all fields at once
	end

endmodule

// ==== pbusCycle.sv ====
`timescale 1ns/1ps

module pbusCycle (
	input logic CLK_24M,
	input logic nRESET,
	input pbusPkg::pbusRequest reqHeld,	// Frame sources
	output pbusPkg::slotIndex slot,	// Current slot
	output logic frameLoad,	// Last slot of the frame
	output pbusPkg::pbusWord pbus,	// Shared P bus
	output logic nVCS	// L0 ROM chip select
);

	pbusPkg::slotKind kind;	// Decoded slot use

	// Free-running slot counter
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			slot <= '0;
		else
			slot <= slot + 1'b1;	// Wraps 15 to 0
	end

	// Slot to bus use
	always_comb
	begin
		if (slot == pbusPkg::fixAddrSlot)
			kind = pbusPkg::SLOT_FIX_ADDR;
		else if ((slot >= pbusPkg::xPosFirstSlot) && (slot <= pbusPkg::xPosLastSlot))
			kind = pbusPkg::SLOT_XPOS;	// Repeated five times
		else if (slot == pbusPkg::fixPalSlot)
			kind = pbusPkg::SLOT_FIX_PAL;
		else if (slot == pbusPkg::sprAddrSlot)
			kind = pbusPkg::SLOT_SPR_ADDR;
		else if ((slot >= pbusPkg::l0FirstSlot) && (slot <= pbusPkg::l0LastSlot))
			kind = pbusPkg::SLOT_L0_ADDR;	// Zoom ROM window
		else if (slot == pbusPkg::sprPalSlot)
			kind = pbusPkg::SLOT_SPR_PAL;
		else
			kind = pbusPkg::SLOT_IDLE;	// Slots 7 and 15
	end

	// Bus word builder
	// Unused bytes stay at zero
	always_comb
	begin
		pbus = '0;
		case (kind)
			pbusPkg::SLOT_FIX_ADDR:
				pbus[15:0] = reqHeld.sAddr;	// Low two bytes
			pbusPkg::SLOT_XPOS:
				pbus[15:8] = reqHeld.sprXPos;	// Middle byte only
			pbusPkg::SLOT_FIX_PAL:
				pbus[19:16] = reqHeld.fixPal;	// Low nibble of top byte
			pbusPkg::SLOT_SPR_ADDR:
				pbus = reqHeld.cAddr;	// Full width
			pbusPkg::SLOT_L0_ADDR:
				pbus[15:0] = reqHeld.l0Addr;	// Held across the window
			pbusPkg::SLOT_SPR_PAL:
				pbus[23:16] = reqHeld.sprPal;	// Top byte
			default:
				pbus = '0;	// Idle slot
		endcase
	end

	assign nVCS = (kind != pbusPkg::SLOT_L0_ADDR);	// Low for slots 9 to 13
	assign frameLoad = (slot == pbusPkg::frameEndSlot);	// Reload point

endmodule

// ==== pbusDemux.sv ====
`timescale 1ns/1ps

module pbusDemux (
	input logic CLK_24M,
	input logic nRESET,
	input pbusPkg::slotIndex slot,	// From the slot counter
	input pbusPkg::pbusWord pbus,	// Shared bus
	input romPkg::romByte l0Data,	// Zoom ROM answer
	output pbusPkg::pbusCapture capOut	// Latched fields
);

	// One strobe per external latch
	typedef struct packed {
		logic fixAddr;
		logic xPos;
		logic fixPal;
		logic sprAddr;
		logic l0Data;
		logic sprPal;
	} capStrobe;

	capStrobe strobe;

	// Each latch closes on the last cycle of its slot
	always_comb
	begin
		strobe.fixAddr = (slot == pbusPkg::fixAddrSlot);
		strobe.xPos = (slot == pbusPkg::xPosLastSlot);	// Last of five X slots
		strobe.fixPal = (slot == pbusPkg::fixPalSlot);
		strobe.sprAddr = (slot == pbusPkg::sprAddrSlot);
		strobe.l0Data = (slot == pbusPkg::l0LastSlot);	// End of nVCS window
		strobe.sprPal = (slot == pbusPkg::sprPalSlot);
	end

	// Field latches
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			capOut <= '0;
		else
		begin
			if (strobe.fixAddr)
				capOut.fixRomAddr <= pbus[15:0];	// Fix ROM board address
			if (strobe.xPos)
				capOut.sprXPos <= pbus[15:8];	// X position byte
			if (strobe.fixPal)
				capOut.fixPal <= pbus[19:16];	// Fix palette nibble
			if (strobe.sprAddr)
				capOut.sprRomAddr <= pbus;	// Whole word
			if (strobe.l0Data)
				capOut.l0Data <= l0Data;	// ROM has settled by now
			if (strobe.sprPal)
				capOut.sprPal <= pbus[23:16];	// Upper byte
		end
	end

endmodule

// ==== pbusTop.sv ====
`timescale 1ns/1ps

module pbusTop (
	input logic CLK_24M,
	input logic nRESET,
	input pbusPkg::pbusRequest reqIn,	// Address sources
	input romPkg::romByte l0Data,	// From the L0 ROM
	output pbusPkg::pbusWord pbus,	// To ROM boards and palette
	output logic nVCS,	// L0 ROM select
	output pbusPkg::pbusCapture capOut	// Demultiplexed values
);

	pbusPkg::pbusRequest reqHeld;	// Frame-stable sources
	pbusPkg::slotIndex slot;	// Shared slot number
	logic frameLoad;	// Reload pulse

	// Input side
	pbusRequestLatch requestLatch (
		.CLK_24M(CLK_24M),
		.nRESET(nRESET),
		.frameLoad(frameLoad),
		.reqIn(reqIn),
		.reqHeld(reqHeld)
	);

	// Slot sequencer and bus driver
	pbusCycle cycle (
		.CLK_24M(CLK_24M),
		.nRESET(nRESET),
		.reqHeld(reqHeld),
		.slot(slot),
		.frameLoad(frameLoad),
		.pbus(pbus),
		.nVCS(nVCS)
	);

	// Output side
	pbusDemux demux (
		.CLK_24M(CLK_24M),
		.nRESET(nRESET),
		.slot(slot),
		.pbus(pbus),
		.l0Data(l0Data),
		.capOut(capOut)
	);

endmodule

// ==== tbPbus.sv ====
`timescale 1ns/1ps

module tbPbus;

	localparam int rowCount = 8;	// Stimulus rows
	localparam int vcsTimeout = 40;	// Cycles allowed to see nVCS fall

	logic CLK_24M;
	logic nRESET;
	pbusPkg::pbusRequest reqIn;
	romPkg::romByte l0Data;
	pbusPkg::pbusWord pbus;
	logic nVCS;
	pbusPkg::pbusCapture capOut;

	pbusPkg::pbusRequest stimTable [rowCount];	// Applied in order
	pbusPkg::pbusRequest zeroReq = '0;	// What reset leaves behind
	integer seed;	// For $random
	int errorCount;

	pbusTop uut (
		.CLK_24M(CLK_24M),
		.nRESET(nRESET),
		.reqIn(reqIn),
		.l0Data(l0Data),
		.pbus(pbus),
		.nVCS(nVCS),
		.capOut(capOut)
	);

	always #5 CLK_24M = ~CLK_24M;	// 10 ns period

	// L0 ROM contents
	function automatic romPkg::romByte romModel(romPkg::l0RomAddr addr);
		return addr[7:0] ^ addr[15:8];
	endfunction

	// L0 ROM answers only while selected
	always_comb
	begin
		if (!nVCS)
			l0Data = romModel(pbus[15:0]);
		else
			l0Data = 8'hff;	// Bus pulled high when deselected
	end

	// Bus layout per slot
	function automatic pbusPkg::pbusWord expectedWord(pbusPkg::pbusRequest r, int s);
		case (s)
			0: return {8'h00, r.sAddr};
			1, 2, 3, 4, 5: return {8'h00, r.sprXPos, 8'h00};
			6: return {4'h0, r.fixPal, 16'h0000};
			8: return r.cAddr;
			9, 10, 11, 12, 13: return {8'h00, r.l0Addr};
			14: return {r.sprPal, 16'h0000};
			default: return 24'h000000;	// Slots 7 and 15
		endcase
	endfunction

	task automatic stopOnFailure();
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic stepCycle();
		@(posedge CLK_24M);
		#1;	// Drive and sample here
	endtask

	task automatic checkWord(string name, pbusPkg::pbusWord expected, pbusPkg::pbusWord actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkByte(string name, romPkg::romByte expected, romPkg::romByte actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkAddr16(string name, romPkg::sRomAddr expected, romPkg::sRomAddr actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkCAddr(string name, romPkg::cRomAddr expected, romPkg::cRomAddr actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkNibble(string name, romPkg::palNibble expected, romPkg::palNibble actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkLevel(string name, logic expected, logic actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
			stopOnFailure();
		end
	endtask

	// Latched fields after the slot 14 edge
	task automatic checkCaptures(pbusPkg::pbusRequest r);
		checkAddr16("capOut.fixRomAddr", r.sAddr, capOut.fixRomAddr);
		checkByte("capOut.sprXPos", r.sprXPos, capOut.sprXPos);
		checkNibble("capOut.fixPal", r.fixPal, capOut.fixPal);
		checkCAddr("capOut.sprRomAddr", r.cAddr, capOut.sprRomAddr);
		checkByte("capOut.sprPal", r.sprPal, capOut.sprPal);
		checkByte("capOut.l0Data", romModel(r.l0Addr), capOut.l0Data);
	endtask

	// Steps until nVCS goes from high to low in slot 9
	task automatic waitVcsFall(input bit idleBus);
		logic prevVcs;
		int waited;
		bit found;
		prevVcs = nVCS;
		waited = 0;
		found = 1'b0;
		while (!found && (waited < vcsTimeout))
		begin
			stepCycle();
			waited++;
			if (idleBus)
				checkWord("pbus", '0, pbus);	// Zero request frame
			if (prevVcs && !nVCS)
				found = 1'b1;
			prevVcs = nVCS;
		end
		if (!found)
		begin
			errorCount++;
			$display("nVCS did not fall within %0d clock cycles", vcsTimeout);
			stopOnFailure();
		end
	endtask

	// Walks slots 0 to 15 of one frame
	task automatic checkFrame(pbusPkg::pbusRequest r);
		for (int s = 0; s < 16; s++)
		begin
			checkLevel("nVCS", !((s >= 9) && (s <= 13)), nVCS);	// 5 low then 11 high
			if (!nVCS)
				checkAddr16("pbus[15:0]", r.l0Addr, pbus[15:0]);	// What the L0 ROM sees
			checkWord("pbus", expectedWord(r, s), pbus);
			if (s == 4)
				reqIn = ~r;	// Mid-frame change kept off the bus
			if (s == 15)
				checkCaptures(r);
			else
				stepCycle();
		end
	endtask

	task automatic buildTable();
		logic [31:0] rnd;
		stimTable[0] = '{sAddr: 16'h1234, fixPal: 4'h5, cAddr: 24'habcdef,
			sprPal: 8'h3c, sprXPos: 8'h9a, l0Addr: 16'h0f1e};
		stimTable[1] = '{sAddr: 16'hffff, fixPal: 4'hf, cAddr: 24'hffffff,
			sprPal: 8'hff, sprXPos: 8'hff, l0Addr: 16'hffff};	// All ones
		stimTable[2] = '{sAddr: 16'haaaa, fixPal: 4'ha, cAddr: 24'h555555,
			sprPal: 8'haa, sprXPos: 8'h55, l0Addr: 16'h5aa5};	// Alternating bits
		stimTable[3] = '{sAddr: 16'h0001, fixPal: 4'h8, cAddr: 24'h800001,
			sprPal: 8'h01, sprXPos: 8'h80, l0Addr: 16'h8001};	// Edge bits
		for (int i = 4; i < rowCount; i++)
		begin
			rnd = $random(seed);
			stimTable[i].sAddr = rnd[15:0];
			stimTable[i].l0Addr = rnd[31:16];
			rnd = $random(seed);
			stimTable[i].cAddr = rnd[23:0];
			stimTable[i].sprPal = rnd[31:24];
			rnd = $random(seed);
			stimTable[i].sprXPos = rnd[7:0];
			stimTable[i].fixPal = rnd[11:8];
		end
	endtask

	initial
	begin
		CLK_24M = 1'b0;
		nRESET = 1'b0;
		seed = 32'had7c;
		errorCount = 0;
		buildTable();
		reqIn = stimTable[0];	// Held off the bus by reset
		repeat (5)
		begin
			stepCycle();
			checkWord("pbus", '0, pbus);
			checkLevel("nVCS", 1'b1, nVCS);
			checkCaptures(zeroReq);	// All latches cleared
		end
		nRESET = 1'b1;
		waitVcsFall(1'b1);	// First frame carries zeros
		for (int i = 0; i < rowCount; i++)
		begin
			waitVcsFall(1'b0);
			reqIn = stimTable[i];	// Taken at the end of slot 15
			repeat (7) stepCycle();	// Slot 9 to slot 0
			checkFrame(stimTable[i]);
		end
		if (errorCount == 0)
		begin
			$display("Verification passed");
			$finish;
		end
		else
			stopOnFailure();
	end

endmodule

// ==== vlog.f ====
romPkg.sv
pbusPkg.sv
pbusRequestLatch.sv
pbusCycle.sv
pbusDemux.sv
pbusTop.sv
tbPbus.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tbPbus
FILELIST ?= vlog.f
OBJDIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Verification passed
VFLAGS ?= --binary --timing --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
